// ==== wb_input.txt ====
# op stall thumb alu alu_pc valid load wi wi1 wd wd1 flags pc8 irq fiq swi und ra0 ra1 cycles
# then expected: pc_nxt pc cpsr clear rd0 rd1 (hex; S step, P step with o_pc, W wait for o_pc)
# After reset: PC counts by 4, pipeline fills with 0, 4, 8.
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 0 0 d3 0 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 4 0 d3 0 0 0
W 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 8 c 0 d3 0 0 0
P 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 10 4 d3 0 0 0
P 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 14 8 d3 0 0 0
# Retire with load writes both ports, then a write to the RAZ slot.
S 0 0 0 0 1 1 3 4 1111 2222 600000d3 0 0 0 0 0 18 18 1 18 0 d3 0 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 4 1 1c 0 600000d3 0 1111 2222
S 0 0 0 0 1 0 18 4 dead 9999 600000d3 0 0 0 0 0 18 18 1 20 0 600000d3 0 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 4 1 24 0 600000d3 0 0 2222
# ALU redirect under stall is shelved, applied once the stall drops.
S 1 0 1 100 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 28 0 600000d3 0 0 0
P 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 3 28 1c 600000d3 0 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 28 0 600000d3 0 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 1 100 0 600000d3 0 0 0
# FIQ and IRQ together, FIQ wins.
S 0 0 0 0 0 0 0 0 4444 0 0 5555 1 1 0 0 18 18 1 104 0 600000d3 1 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 10 11 1 1c 0 600000d1 0 4444 600000d3
# Load to PC with an odd address enters Thumb state.
S 0 0 0 0 1 1 2 f 77 201 d3 0 0 0 0 0 18 18 1 20 0 600000d1 1 0 0
S 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 f 1 200 0 f3 0 77 201
S 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 2 204 0 f3 0 0 0
# SWI from Thumb links with pc_plus_8, UND from ARM links with wr_data.
S 0 1 0 0 0 0 0 0 88 0 0 20c 0 0 1 0 18 18 1 206 0 f3 1 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 14 15 1 8 0 d3 0 20c f3
S 0 0 0 0 0 0 0 0 99 0 0 0 0 0 0 1 18 18 1 c 0 d3 1 0 0
S 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 16 17 1 4 0 db 0 99 d3
W 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 18 18 8 10 4 db 0 0 0

// ==== src.f ====
wb_pkg.sv
wb_register_file.sv
wb_pc_sequencer.sv
wb_event_ctrl.sv
wb_writeback.sv
tb_writeback.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the writeback testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_writeback -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/Vtb_writeback > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
        echo "simulation passed"
        exit 0
fi

echo "simulation failed"
exit 1

// ==== tb_writeback.sv ====
`timescale 1ns/1ns

module tb_writeback;

import wb_pkg::*;

// Sample point inside the low clock phase.
localparam int SAMPLE_DELAY = 4;
localparam int FIELD_COUNT  = 26;

// --------------------------------------------------
// DUT connections.
// --------------------------------------------------

logic              clk;
logic              reset;
logic              code_stall;
logic              thumb;
logic              clear_from_alu;
logic [WORD_W-1:0] pc_from_alu;
logic              clear_from_decode;
logic [WORD_W-1:0] pc_from_decode;
logic              valid;
logic              mem_load;
logic [IDX_W-1:0]  wr_index;
logic [IDX_W-1:0]  wr_index_1;
logic [WORD_W-1:0] wr_data;
logic [WORD_W-1:0] wr_data_1;
logic [WORD_W-1:0] flags;
logic [WORD_W-1:0] pc_plus_8;
logic              irq;
logic              fiq;
logic              swi;
logic              und;
logic [IDX_W-1:0]  rd_index_0;
logic [IDX_W-1:0]  rd_index_1;
logic [WORD_W-1:0] rd_data_0;
logic [WORD_W-1:0] rd_data_1;
logic [WORD_W-1:0] pc_nxt;
logic [WORD_W-1:0] pc;
logic              pc_valid;
logic              clear_from_writeback;
logic [WORD_W-1:0] cpsr;

// One parsed line of the stimulus file.
logic [7:0]        op;
logic [31:0]       f_stall, f_thumb, f_alu, f_alu_pc;
logic [31:0]       f_valid, f_load, f_wi, f_wi1, f_wd, f_wd1;
logic [31:0]       f_flags, f_pc8, f_irq, f_fiq, f_swi, f_und;
logic [31:0]       f_ra0, f_ra1, f_cycles;
logic [31:0]       e_pc_nxt, e_pc, e_cpsr, e_clr, e_rd0, e_rd1;

int                fd;
int                line_no;
int                steps;

wb_writeback dut
(
        .i_clk                  (clk),
        .i_reset                (reset),
        .i_code_stall           (code_stall),
        .i_thumb                (thumb),
        .i_clear_from_alu       (clear_from_alu),
        .i_pc_from_alu          (pc_from_alu),
        .i_clear_from_decode    (clear_from_decode),
        .i_pc_from_decode       (pc_from_decode),
        .i_valid                (valid),
        .i_mem_load             (mem_load),
        .i_wr_index             (wr_index),
        .i_wr_index_1           (wr_index_1),
        .i_wr_data              (wr_data),
        .i_wr_data_1            (wr_data_1),
        .i_flags                (flags),
        .i_pc_plus_8            (pc_plus_8),
        .i_irq                  (irq),
        .i_fiq                  (fiq),
        .i_swi                  (swi),
        .i_und                  (und),
        .i_rd_index_0           (rd_index_0),
        .i_rd_index_1           (rd_index_1),
        .o_rd_data_0            (rd_data_0),
        .o_rd_data_1            (rd_data_1),
        .o_pc_nxt               (pc_nxt),
        .o_pc                   (pc),
        .o_pc_valid             (pc_valid),
        .o_clear_from_writeback (clear_from_writeback),
        .o_cpsr                 (cpsr)
);

// 10 ns clock.
initial
begin
        clk = 1'b0;
        forever #5 clk = ~clk;
end

// --------------------------------------------------
// Helpers.
// --------------------------------------------------

task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
endtask

task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
                abort_run($sformatf("error: time %0t: line %0d: %s is %h, expected %h",
                                    $time, line_no, what, got, exp));
endtask

// Copy the parsed fields onto the DUT inputs.
task automatic drive_inputs();
        code_stall     = f_stall[0];
        thumb          = f_thumb[0];
        clear_from_alu = f_alu[0];
        pc_from_alu    = f_alu_pc;
        valid          = f_valid[0];
        mem_load       = f_load[0];
        wr_index       = f_wi[IDX_W-1:0];
        wr_index_1     = f_wi1[IDX_W-1:0];
        wr_data        = f_wd;
        wr_data_1      = f_wd1;
        flags          = f_flags;
        pc_plus_8      = f_pc8;
        irq            = f_irq[0];
        fiq            = f_fiq[0];
        swi            = f_swi[0];
        und            = f_und[0];
        rd_index_0     = f_ra0[IDX_W-1:0];
        rd_index_1     = f_ra1[IDX_W-1:0];
endtask

task automatic check_outputs(input bit with_pc);
        compare("o_pc_nxt", pc_nxt, e_pc_nxt);
        compare("o_cpsr", cpsr, e_cpsr);
        compare("o_clear_from_writeback", {31'b0, clear_from_writeback}, e_clr);
        compare("o_rd_data_0", rd_data_0, e_rd0);
        compare("o_rd_data_1", rd_data_1, e_rd1);
        if (with_pc)
        begin
                compare("o_pc_valid", {31'b0, pc_valid}, 32'd1);
                compare("o_pc", pc, e_pc);
        end
endtask

// Hold the inputs for f_cycles edges. Check before the last one.
task automatic hold_and_check(input bit with_pc);
        int cycles;
        int n;
        cycles = int'(f_cycles);
        drive_inputs();
        for (n = 1; n < cycles; n++)
                @(negedge clk);
        #SAMPLE_DELAY;
        check_outputs(with_pc);
        @(negedge clk);
endtask

// Bounded wait for o_pc_valid. The limit is f_cycles.
task automatic wait_pc_valid();
        int limit;
        int waited;
        limit  = int'(f_cycles);
        waited = 0;
        drive_inputs();
        #SAMPLE_DELAY;
        while (!pc_valid)
        begin
                if (waited >= limit)
                        abort_run($sformatf("o_pc_valid did not rise within %0d cycles (line %0d)",
                                            limit, line_no));
                @(negedge clk);
                #SAMPLE_DELAY;
                waited++;
        end
        check_outputs(1'b1);
        @(negedge clk);
endtask

// --------------------------------------------------
// Main sequence.
// --------------------------------------------------

initial
begin
        string line;
        int    code;
        int    n_fields;

        // Quiet inputs. The decoder redirect stays idle.
        reset             = 1'b1;
        code_stall        = 1'b0;
        thumb             = 1'b0;
        clear_from_alu    = 1'b0;
        pc_from_alu       = '0;
        clear_from_decode = 1'b0;
        pc_from_decode    = '0;
        valid             = 1'b0;
        mem_load          = 1'b0;
        wr_index          = '0;
        wr_index_1        = '0;
        wr_data           = '0;
        wr_data_1         = '0;
        flags             = '0;
        pc_plus_8         = '0;
        irq               = 1'b0;
        fiq               = 1'b0;
        swi               = 1'b0;
        und               = 1'b0;
        rd_index_0        = PHY_RAZ_REGISTER;
        rd_index_1        = PHY_RAZ_REGISTER;
        line_no           = 0;
        steps             = 0;

        fd = $fopen("wb_input.txt", "r");
        if (fd == 0)
                abort_run("could not open wb_input.txt for reading");

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (!$feof(fd))
        begin
                code = $fgets(line, fd);
                line_no++;
                // Skip comments and blank lines.
                if (code == 0 || line.len() < 2 || line.getc(0) == "#")
                        continue;
                n_fields = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        op, f_stall, f_thumb, f_alu, f_alu_pc, f_valid, f_load,
                        f_wi, f_wi1, f_wd, f_wd1, f_flags, f_pc8,
                        f_irq, f_fiq, f_swi, f_und, f_ra0, f_ra1, f_cycles,
                        e_pc_nxt, e_pc, e_cpsr, e_clr, e_rd0, e_rd1);
                if (n_fields != FIELD_COUNT)
                        abort_run($sformatf("line %0d of wb_input.txt has %0d fields, not %0d",
                                            line_no, n_fields, FIELD_COUNT));
                if (op == "S")
                        hold_and_check(1'b0);
                else if (op == "P")
                        hold_and_check(1'b1);
                else if (op == "W")
                        wait_pc_valid();
                else
                        abort_run($sformatf("unknown opcode on line %0d", line_no));
                steps++;
        end
        $fclose(fd);

        if (steps == 0)
                abort_run("wb_input.txt holds no steps");
        else
        begin
                $display("PASS: all tests");
                $finish;
        end
end

endmodule

// ==== wb_writeback.sv ====
`timescale 1ns/1ns

module wb_writeback
(
        input  logic                      i_clk,
        input  logic                      i_reset,

        // Fetch control.
        input  logic                      i_code_stall,
        input  logic                      i_thumb,
        input  logic                      i_clear_from_alu,
        input  logic [wb_pkg::WORD_W-1:0] i_pc_from_alu,
        input  logic                      i_clear_from_decode,
        input  logic [wb_pkg::WORD_W-1:0] i_pc_from_decode,

        // Retire.
        input  logic                      i_valid,
        input  logic                      i_mem_load,
        input  logic [wb_pkg::IDX_W-1:0]  i_wr_index,
        input  logic [wb_pkg::IDX_W-1:0]  i_wr_index_1,
        input  logic [wb_pkg::WORD_W-1:0] i_wr_data,
        input  logic [wb_pkg::WORD_W-1:0] i_wr_data_1,
        input  logic [wb_pkg::WORD_W-1:0] i_flags,
        input  logic [wb_pkg::WORD_W-1:0] i_pc_plus_8,

        // Exceptions.
        input  logic                      i_irq,
        input  logic                      i_fiq,
        input  logic                      i_swi,
        input  logic                      i_und,

        // Register reads.
        input  logic [wb_pkg::IDX_W-1:0]  i_rd_index_0,
        input  logic [wb_pkg::IDX_W-1:0]  i_rd_index_1,
        output logic [wb_pkg::WORD_W-1:0] o_rd_data_0,
        output logic [wb_pkg::WORD_W-1:0] o_rd_data_1,

        output logic [wb_pkg::WORD_W-1:0] o_pc_nxt,
        output logic [wb_pkg::WORD_W-1:0] o_pc,
        output logic                      o_pc_valid,
        output logic                      o_clear_from_writeback,
        output logic [wb_pkg::WORD_W-1:0] o_cpsr
);

import wb_pkg::*;

// Event controller to register file.
logic              wen;
logic [IDX_W-1:0]  wa_a, wa_b;
logic [WORD_W-1:0] wd_a, wd_b;

// Event controller to PC sequencer.
logic              wb_redirect;
logic [WORD_W-1:0] wb_redirect_pc;

wb_event_ctrl u_event_ctrl
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_valid                (i_valid),
        .i_mem_load             (i_mem_load),
        .i_wr_index             (i_wr_index),
        .i_wr_index_1           (i_wr_index_1),
        .i_wr_data              (i_wr_data),
        .i_wr_data_1            (i_wr_data_1),
        .i_flags                (i_flags),
        .i_pc_plus_8            (i_pc_plus_8),
        .i_irq                  (i_irq),
        .i_fiq                  (i_fiq),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .o_wen                  (wen),
        .o_wa_a                 (wa_a),
        .o_wa_b                 (wa_b),
        .o_wd_a                 (wd_a),
        .o_wd_b                 (wd_b),
        .o_wb_redirect          (wb_redirect),
        .o_wb_redirect_pc       (wb_redirect_pc),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_cpsr                 (o_cpsr)
);

wb_pc_sequencer u_pc_sequencer
(
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_code_stall        (i_code_stall),
        .i_thumb             (i_thumb),
        .i_wb_redirect       (wb_redirect),
        .i_wb_redirect_pc    (wb_redirect_pc),
        .i_clear_from_alu    (i_clear_from_alu),
        .i_pc_from_alu       (i_pc_from_alu),
        .i_clear_from_decode (i_clear_from_decode),
        .i_pc_from_decode    (i_pc_from_decode),
        .o_pc_nxt            (o_pc_nxt),
        .o_pc                (o_pc),
        .o_pc_valid          (o_pc_valid)
);

wb_register_file u_register_file
(
        .i_clk  (i_clk),
        .i_wen  (wen),
        .i_wa_a (wa_a),
        .i_wa_b (wa_b),
        .i_wd_a (wd_a),
        .i_wd_b (wd_b),
        .i_ra_0 (i_rd_index_0),
        .i_ra_1 (i_rd_index_1),
        .o_rd_0 (o_rd_data_0),
        .o_rd_1 (o_rd_data_1)
);

endmodule

// ==== wb_event_ctrl.sv ====
`timescale 1ns/1ns

module wb_event_ctrl
(
        input  logic                      i_clk,
        input  logic                      i_reset,

        // Retiring instruction.
        input  logic                      i_valid,
        input  logic                      i_mem_load,
        input  logic [wb_pkg::IDX_W-1:0]  i_wr_index,
        input  logic [wb_pkg::IDX_W-1:0]  i_wr_index_1,
        input  logic [wb_pkg::WORD_W-1:0] i_wr_data,
        input  logic [wb_pkg::WORD_W-1:0] i_wr_data_1,
        input  logic [wb_pkg::WORD_W-1:0] i_flags,
        input  logic [wb_pkg::WORD_W-1:0] i_pc_plus_8,

        // Exception requests.
        input  logic                      i_irq,
        input  logic                      i_fiq,
        input  logic                      i_swi,
        input  logic                      i_und,

        // Register file writes.
        output logic                      o_wen,
        output logic [wb_pkg::IDX_W-1:0]  o_wa_a,
        output logic [wb_pkg::IDX_W-1:0]  o_wa_b,
        output logic [wb_pkg::WORD_W-1:0] o_wd_a,
        output logic [wb_pkg::WORD_W-1:0] o_wd_b,

        output logic                      o_wb_redirect,
        output logic [wb_pkg::WORD_W-1:0] o_wb_redirect_pc,
        output logic                      o_clear_from_writeback,
        output logic [wb_pkg::WORD_W-1:0] o_cpsr
);

import wb_pkg::*;

logic [WORD_W-1:0] cpsr_ff, cpsr_nxt;

// Selected exception, if any.
logic              exc;
logic [WORD_W-1:0] exc_vector;
logic [IDX_W-1:0]  exc_r14;
logic [IDX_W-1:0]  exc_spsr;
logic [MODE_W-1:0] exc_mode;

// Return address depends on current state.
logic [WORD_W-1:0] link;
logic              load_pc;

assign o_cpsr  = cpsr_ff;
assign link    = cpsr_ff[CPSR_T] ? i_pc_plus_8 : i_wr_data;
assign load_pc = i_valid && i_mem_load && (i_wr_index_1 == ARCH_PC);

// --------------------------------------------------
// Exception select in priority order.
// --------------------------------------------------

always_comb
begin
        exc        = 1'b1;
        exc_vector = UND_VECTOR;
        exc_r14    = PHY_UND_R14;
        exc_spsr   = PHY_UND_SPSR;
        exc_mode   = MODE_UND;

        if (i_fiq)
        begin
                exc_vector = FIQ_VECTOR;
                exc_r14    = PHY_FIQ_R14;
                exc_spsr   = PHY_FIQ_SPSR;
                exc_mode   = MODE_FIQ;
        end
        else if (i_irq)
        begin
                exc_vector = IRQ_VECTOR;
                exc_r14    = PHY_IRQ_R14;
                exc_spsr   = PHY_IRQ_SPSR;
                exc_mode   = MODE_IRQ;
        end
        else if (i_swi)
        begin
                exc_vector = SWI_VECTOR;
                exc_r14    = PHY_SVC_R14;
                exc_spsr   = PHY_SVC_SPSR;
                exc_mode   = MODE_SVC;
        end
        else if (!i_und)
        begin
                exc = 1'b0;
        end
end

// --------------------------------------------------
// Writes, redirect and next CPSR.
// --------------------------------------------------

always_comb
begin
        o_wen                  = 1'b0;
        o_wa_a                 = PHY_RAZ_REGISTER;
        o_wa_b                 = PHY_RAZ_REGISTER;
        o_wd_a                 = '0;
        o_wd_b                 = '0;
        o_wb_redirect          = 1'b0;
        o_wb_redirect_pc       = '0;
        o_clear_from_writeback = 1'b0;
        cpsr_nxt               = cpsr_ff;

        if (exc)
        begin
                // Bank the link and the old CPSR.
                o_wen  = 1'b1;
                o_wa_a = exc_r14;
                o_wd_a = link;
                o_wa_b = exc_spsr;
                o_wd_b = cpsr_ff;

                o_wb_redirect          = 1'b1;
                o_wb_redirect_pc       = exc_vector;
                o_clear_from_writeback = 1'b1;

                // Enter the mode in ARM state with IRQ masked.
                cpsr_nxt[MODE_W-1:0] = exc_mode;
                cpsr_nxt[CPSR_I]     = 1'b1;
                cpsr_nxt[CPSR_T]     = 1'b0;
                if (i_fiq)
                        cpsr_nxt[CPSR_F] = 1'b1;
        end
        else if (i_valid)
        begin
                o_wen    = 1'b1;
                o_wa_a   = i_wr_index;
                o_wd_a   = i_wr_data;
                o_wa_b   = i_mem_load ? i_wr_index_1 : PHY_RAZ_REGISTER;
                o_wd_b   = i_wr_data_1;
                cpsr_nxt = i_flags;

                // Load to PC. Bit 0 picks the new state.
                if (load_pc)
                begin
                        o_wb_redirect          = 1'b1;
                        o_wb_redirect_pc       = i_wr_data_1;
                        o_clear_from_writeback = 1'b1;
                        cpsr_nxt[CPSR_T]       = i_wr_data_1[0];
                end
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
                cpsr_ff <= CPSR_RESET;
        else
                cpsr_ff <= cpsr_nxt;
end

a_clear_has_target: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_clear_from_writeback |-> o_wb_redirect
);

endmodule

// ==== wb_pc_sequencer.sv ====
`timescale 1ns/1ns

module wb_pc_sequencer
(
        input  logic                      i_clk,
        input  logic                      i_reset,

        // Flow control and fetch state.
        input  logic                      i_code_stall,
        input  logic                      i_thumb,

        // Redirect sources, highest priority first.
        input  logic                      i_wb_redirect,
        input  logic [wb_pkg::WORD_W-1:0] i_wb_redirect_pc,
        input  logic                      i_clear_from_alu,
        input  logic [wb_pkg::WORD_W-1:0] i_pc_from_alu,
        input  logic                      i_clear_from_decode,
        input  logic [wb_pkg::WORD_W-1:0] i_pc_from_decode,

        output logic [wb_pkg::WORD_W-1:0] o_pc_nxt,
        output logic [wb_pkg::WORD_W-1:0] o_pc,
        output logic                      o_pc_valid
);

import wb_pkg::*;

// --------------------------------------------------
// State.
// --------------------------------------------------

// Fetch PC, which is always valid.
logic [WORD_W-1:0] pc_ff, pc_nxt;

// Three delay stages with valid bits.
logic [WORD_W-1:0] del_pc_ff [3];
logic [WORD_W-1:0] del_pc_nxt [3];
logic [2:0]        del_vld_ff, del_vld_nxt;

// Redirect that arrived during a stall.
logic              shelve_ff, shelve_nxt;
logic [WORD_W-1:0] shelve_pc_ff, shelve_pc_nxt;

logic              redirect;
logic [WORD_W-1:0] redirect_pc;

assign o_pc_nxt   = pc_ff;
assign o_pc       = del_pc_ff[2];
assign o_pc_valid = del_vld_ff[2];

// --------------------------------------------------
// Redirect source select.
// --------------------------------------------------

assign redirect = i_wb_redirect | i_clear_from_alu | i_clear_from_decode;

always_comb
begin
        if (i_wb_redirect)
                redirect_pc = i_wb_redirect_pc;
        else if (i_clear_from_alu)
                redirect_pc = i_pc_from_alu;
        else
                redirect_pc = i_pc_from_decode;
end

// --------------------------------------------------
// Next state.
// --------------------------------------------------

always_comb
begin
        // Hold everything by default.
        pc_nxt        = pc_ff;
        del_pc_nxt    = del_pc_ff;
        del_vld_nxt   = del_vld_ff;
        shelve_nxt    = shelve_ff;
        shelve_pc_nxt = shelve_pc_ff;

        if (redirect && i_code_stall)
        begin
                // Park the target while the stages stay put.
                shelve_nxt    = 1'b1;
                shelve_pc_nxt = redirect_pc;
        end
        else if (redirect)
        begin
                // Jump. Older stages keep their addresses as bubbles.
                pc_nxt      = {redirect_pc[WORD_W-1:1], 1'b0};
                del_vld_nxt = 3'b000;
                shelve_nxt  = 1'b0;
        end
        else if (i_code_stall)
        begin
                // Nothing moves.
        end
        else if (shelve_ff)
        begin
                pc_nxt      = {shelve_pc_ff[WORD_W-1:1], 1'b0};
                del_vld_nxt = 3'b000;
                shelve_nxt  = 1'b0;
        end
        else
        begin
                pc_nxt        = pc_ff + (i_thumb ? WORD_W'(2) : WORD_W'(4));
                del_pc_nxt[0] = pc_ff;
                del_pc_nxt[1] = del_pc_ff[0];
                del_pc_nxt[2] = del_pc_ff[1];
                del_vld_nxt   = {del_vld_ff[1:0], 1'b1};
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff      <= '0;
                del_vld_ff <= '0;
                shelve_ff  <= 1'b0;
        end
        else
        begin
                pc_ff      <= pc_nxt;
                del_vld_ff <= del_vld_nxt;
                shelve_ff  <= shelve_nxt;
        end
end

// Stage and shelve addresses are qualified by the valid bits.
always_ff @(posedge i_clk)
begin
        del_pc_ff    <= del_pc_nxt;
        shelve_pc_ff <= shelve_pc_nxt;
end

a_pc_nxt_aligned: assert property (@(posedge i_clk) o_pc_nxt[0] == 1'b0);

a_stall_holds_pc: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_code_stall |=> $stable(o_pc)
);

endmodule

// ==== wb_register_file.sv ====
`timescale 1ns/1ns

module wb_register_file
(
        input  logic                      i_clk,

        // Write ports, shared enable.
        input  logic                      i_wen,
        input  logic [wb_pkg::IDX_W-1:0]  i_wa_a,
        input  logic [wb_pkg::IDX_W-1:0]  i_wa_b,
        input  logic [wb_pkg::WORD_W-1:0] i_wd_a,
        input  logic [wb_pkg::WORD_W-1:0] i_wd_b,

        // Read ports.
        input  logic [wb_pkg::IDX_W-1:0]  i_ra_0,
        input  logic [wb_pkg::IDX_W-1:0]  i_ra_1,
        output logic [wb_pkg::WORD_W-1:0] o_rd_0,
        output logic [wb_pkg::WORD_W-1:0] o_rd_1
);

import wb_pkg::*;

// --------------------------------------------------
// Storage.
// --------------------------------------------------

logic [WORD_W-1:0] regs [PHY_REGS];

// Indices at or above the RAZ slot hold nothing.
logic              wr_ok_a;
logic              wr_ok_b;

assign wr_ok_a = (i_wa_a < PHY_RAZ_REGISTER);
assign wr_ok_b = (i_wa_b < PHY_RAZ_REGISTER);

// Both ports land on the same edge.
always_ff @(posedge i_clk)
begin
        if (i_wen && wr_ok_a)
        begin
                regs[i_wa_a] <= i_wd_a;
        end

        if (i_wen && wr_ok_b)
        begin
                regs[i_wa_b] <= i_wd_b;
        end
end

// --------------------------------------------------
// Combinational reads.
// --------------------------------------------------

// RAZ slot and unused indices read as zero.
assign o_rd_0 = (i_ra_0 < PHY_RAZ_REGISTER) ? regs[i_ra_0] : '0;
assign o_rd_1 = (i_ra_1 < PHY_RAZ_REGISTER) ? regs[i_ra_1] : '0;

// Event controller must never aim both ports at one live slot.
a_no_write_clash: assert property (
        @(posedge i_clk)
        i_wen |-> ((i_wa_a != i_wa_b) ||
                   (i_wa_a == PHY_RAZ_REGISTER) ||
                   (i_wa_b == PHY_RAZ_REGISTER))
);

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

        // ------------------------------------------------
        // Widths.
        // ------------------------------------------------

        // Data and address width.
        localparam int WORD_W   = 32;

        // Physical slots, including the read-as-zero slot.
        localparam int PHY_REGS = 25;
        localparam int IDX_W    = 5;

        // ------------------------------------------------
        // Register indices.
        // ------------------------------------------------

        // Architectural PC.
        localparam logic [IDX_W-1:0] ARCH_PC          = IDX_W'(15);

        // Banked link and SPSR slots, one pair per mode.
        localparam logic [IDX_W-1:0] PHY_FIQ_R14      = IDX_W'(16);
        localparam logic [IDX_W-1:0] PHY_FIQ_SPSR     = IDX_W'(17);
        localparam logic [IDX_W-1:0] PHY_IRQ_R14      = IDX_W'(18);
        localparam logic [IDX_W-1:0] PHY_IRQ_SPSR     = IDX_W'(19);
        localparam logic [IDX_W-1:0] PHY_SVC_R14      = IDX_W'(20);
        localparam logic [IDX_W-1:0] PHY_SVC_SPSR     = IDX_W'(21);
        localparam logic [IDX_W-1:0] PHY_UND_R14      = IDX_W'(22);
        localparam logic [IDX_W-1:0] PHY_UND_SPSR     = IDX_W'(23);

        // Writes dropped, reads give zero.
        localparam logic [IDX_W-1:0] PHY_RAZ_REGISTER = IDX_W'(24);

        // ------------------------------------------------
        // CPSR layout and mode codes.
        // ------------------------------------------------

        localparam int CPSR_T = 5;
        localparam int CPSR_F = 6;
        localparam int CPSR_I = 7;

        // Mode field sits in bits 4 to 0.
        localparam int MODE_W = 5;

        localparam logic [MODE_W-1:0] MODE_FIQ = MODE_W'(17);
        localparam logic [MODE_W-1:0] MODE_IRQ = MODE_W'(18);
        localparam logic [MODE_W-1:0] MODE_SVC = MODE_W'(19);
        localparam logic [MODE_W-1:0] MODE_UND = MODE_W'(27);

        // ------------------------------------------------
        // Exception vectors.
        // ------------------------------------------------

        localparam logic [WORD_W-1:0] UND_VECTOR = WORD_W'('h04);
        localparam logic [WORD_W-1:0] SWI_VECTOR = WORD_W'('h08);
        localparam logic [WORD_W-1:0] IRQ_VECTOR = WORD_W'('h18);
        localparam logic [WORD_W-1:0] FIQ_VECTOR = WORD_W'('h1C);

        // Supervisor mode, both interrupts masked, ARM state.
        localparam logic [WORD_W-1:0] CPSR_RESET = (WORD_W'(1) << CPSR_I) |
                                                   (WORD_W'(1) << CPSR_F) |
                                                   WORD_W'(MODE_SVC);

endpackage
